/* logic/demodPkg.sv */
/* Datapath widths, sample types and the local-oscillator table.
   LO_STEPS must be a power of two because the phase index wraps by truncation. */
package demodPkg;

    localparam int ADC_WIDTH = 16;
    localparam int LO_WIDTH = 18;

    // one bit narrower than a full product
    // the oscillator word never reaches negative full scale
    localparam int PRODUCT_WIDTH = ADC_WIDTH + LO_WIDTH - 1;

    localparam int LO_STEPS = 8;
    localparam int PHASE_WIDTH = $clog2(LO_STEPS);

    // room for one full turn of products
    localparam int ACC_WIDTH = PRODUCT_WIDTH + PHASE_WIDTH;

    ////////////////////////////////////////
    // sample and arithmetic types

    typedef logic signed [ADC_WIDTH-1:0] adcSampleT;
    typedef logic signed [LO_WIDTH-1:0] loWordT;
    typedef logic signed [PRODUCT_WIDTH-1:0] productT;
    typedef logic signed [ACC_WIDTH-1:0] accumT;
    typedef logic [PHASE_WIDTH-1:0] phaseT;

    ////////////////////////////////////////
    // oscillator table

    // the sine word at step k is the cosine word at step k-2
    localparam loWordT LO_COS_TABLE [LO_STEPS] = '{
        18'sd131071,
        18'sd92681,
        18'sd0,
        -18'sd92681,
        -18'sd131071,
        -18'sd92681,
        18'sd0,
        18'sd92681
    };

endpackage

/* logic/csrPkg.sv */
/* Register map of the host interface.
   Addresses 2 and 3 are unused. The clear-overflow bit is never stored. */
package csrPkg;

    localparam int CSR_WIDTH = 32;

    typedef enum logic [2:0] {
        ADDR_CONTROL   = 3'd0,
        ADDR_SUM_SHIFT = 3'd1,
        ADDR_GAIN0     = 3'd4,
        ADDR_GAIN1     = 3'd5,
        ADDR_GAIN2     = 3'd6,
        ADDR_GAIN3     = 3'd7
    } csrAddrT;

    ////////////////////////////////////////
    // control word bits

    localparam int CTRL_USE_RMS = 0;
    // write-only pulse
    localparam int CTRL_CLEAR_OVERFLOW = 1;
    // sticky flag, readback only
    localparam int CTRL_OVERFLOW_FLAG = 31;

    ////////////////////////////////////////
    // scaling

    localparam int SHIFT_WIDTH = 4;
    localparam int GAIN_FRAC_BITS = 24;
    localparam int GAIN_UNITY = 2 ** GAIN_FRAC_BITS;

endpackage

/* logic/localOscillator.sv */
/* Phase advances only on valid samples, so gaps stall the turn.
   syncStrobe acts only on a cycle that also carries adcValid. */
`timescale 1ns/1ps

module localOscillator
    import demodPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   adcValid,
    input  logic   syncStrobe,
    output logic   loValid,
    output loWordT loCos,
    output loWordT loSin,
    output logic   turnStart,
    output logic   turnEnd
);

    localparam phaseT LAST_STEP = phaseT'(LO_STEPS - 1);

    phaseT phase;
    phaseT stepPhase;

    // sync forces the arriving sample onto step 0
    assign stepPhase = syncStrobe ? '0 : phase;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase     <= '0;
            loValid   <= 1'b0;
            turnStart <= 1'b0;
            turnEnd   <= 1'b0;
        end else begin
            loValid   <= adcValid;
            turnStart <= adcValid && (stepPhase == '0);
            turnEnd   <= adcValid && (stepPhase == LAST_STEP);
            if (adcValid) begin
                phase <= (stepPhase == LAST_STEP) ? '0 : stepPhase + 1'b1;
            end
        end
    end

    // sine lookup two steps behind cosine
    always_ff @(posedge clk) begin
        if (adcValid) begin
            loCos <= LO_COS_TABLE[stepPhase];
            loSin <= LO_COS_TABLE[phaseT'(stepPhase - 2)];
        end
    end

endmodule

/* logic/demodMixer.sv */
/* Samples and gate are taken one cycle before the matching oscillator words.
   In RMS mode the sample replaces cosine, so I is twice the sample squared. */
`timescale 1ns/1ps

module demodMixer
    import demodPkg::*;
#(
    parameter int NADC = 4
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      loValid,
    input  loWordT    loCos,
    input  loWordT    loSin,
    input  logic      turnStart,
    input  logic      turnEnd,
    input  adcSampleT adcSample [NADC],
    input  logic      useThisSample,
    input  logic      useRms,
    output logic      prodValid,
    output productT   prodI [NADC],
    output productT   prodQ [NADC],
    output logic      prodTurnStart,
    output logic      prodTurnEnd
);

    adcSampleT sampleD [NADC];
    logic      gateD;
    adcSampleT mixSample [NADC];
    loWordT    mixCos [NADC];
    loWordT    mixSin [NADC];

    // align with the registered table words
    always_ff @(posedge clk) begin
        sampleD <= adcSample;
        gateD   <= useThisSample;
    end

    always_comb begin
        for (int ch = 0; ch < NADC; ch++) begin
            mixSample[ch] = (useRms && !gateD) ? '0 : sampleD[ch];
            // sample one bit short of full scale
            mixCos[ch] = useRms ?
                {mixSample[ch][ADC_WIDTH-1], mixSample[ch], {(LO_WIDTH - ADC_WIDTH - 1){1'b0}}} :
                loCos;
            mixSin[ch] = useRms ? '0 : loSin;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            prodValid     <= 1'b0;
            prodTurnStart <= 1'b0;
            prodTurnEnd   <= 1'b0;
        end else begin
            prodValid     <= loValid;
            prodTurnStart <= turnStart;
            prodTurnEnd   <= turnEnd;
        end
    end

    always_ff @(posedge clk) begin
        if (loValid) begin
            for (int ch = 0; ch < NADC; ch++) begin
                prodI[ch] <= mixSample[ch] * mixCos[ch];
                prodQ[ch] <= mixSample[ch] * mixSin[ch];
            end
        end
    end

endmodule

/* logic/turnAccumulator.sv */
/* Sums one turn of I/Q products per channel. The sum restarts on turn start.
   At turn end the full sum is shifted right and clipped to signed MAG_WIDTH. */
`timescale 1ns/1ps

module turnAccumulator
    import demodPkg::*;
    import csrPkg::*;
#(
    parameter int NADC = 4,
    parameter int MAG_WIDTH = 26
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        prodValid,
    input  productT                     prodI [NADC],
    input  productT                     prodQ [NADC],
    input  logic                        prodTurnStart,
    input  logic                        prodTurnEnd,
    input  logic [SHIFT_WIDTH-1:0]      sumShift,
    output logic                        sumValid,
    output logic signed [MAG_WIDTH-1:0] sumI [NADC],
    output logic signed [MAG_WIDTH-1:0] sumQ [NADC],
    output logic                        overflow
);

    localparam accumT SUM_MAX = (accumT'(1) <<< (MAG_WIDTH - 1)) - accumT'(1);
    localparam accumT SUM_MIN = -SUM_MAX - accumT'(1);

    accumT                       accI [NADC];
    accumT                       accQ [NADC];
    accumT                       fullI [NADC];
    accumT                       fullQ [NADC];
    logic signed [MAG_WIDTH-1:0] clipI [NADC];
    logic signed [MAG_WIDTH-1:0] clipQ [NADC];
    logic [NADC-1:0]             satI;
    logic [NADC-1:0]             satQ;

    // result is {clipped, value}
    function automatic logic [MAG_WIDTH:0] scaleSum(input accumT sum,
                                                    input logic [SHIFT_WIDTH-1:0] shift);
        accumT scaled;
        scaled = sum >>> shift;
        if (scaled > SUM_MAX) begin
            return {1'b1, SUM_MAX[MAG_WIDTH-1:0]};
        end else if (scaled < SUM_MIN) begin
            return {1'b1, SUM_MIN[MAG_WIDTH-1:0]};
        end
        return {1'b0, scaled[MAG_WIDTH-1:0]};
    endfunction

    ////////////////////////////////////////
    // running sum including the current product

    always_comb begin
        for (int ch = 0; ch < NADC; ch++) begin
            fullI[ch] = accumT'(prodI[ch]);
            fullQ[ch] = accumT'(prodQ[ch]);
            if (!prodTurnStart) begin
                fullI[ch] = fullI[ch] + accI[ch];
                fullQ[ch] = fullQ[ch] + accQ[ch];
            end
            {satI[ch], clipI[ch]} = scaleSum(fullI[ch], sumShift);
            {satQ[ch], clipQ[ch]} = scaleSum(fullQ[ch], sumShift);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sumValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            sumValid <= prodValid && prodTurnEnd;
            overflow <= prodValid && prodTurnEnd && ((|satI) || (|satQ));
        end
    end

    always_ff @(posedge clk) begin
        if (prodValid) begin
            accI <= fullI;
            accQ <= fullQ;
        end
        if (prodValid && prodTurnEnd) begin
            sumI <= clipI;
            sumQ <= clipQ;
        end
    end

endmodule

/* logic/magnitudeTrim.sv */
/* Magnitude estimate is max(|I|,|Q|) + floor(min(|I|,|Q|)/2), not a true norm.
   Gains are unsigned with GAIN_FRAC_BITS fraction bits; GAIN_WIDTH > GAIN_FRAC_BITS. */
`timescale 1ns/1ps

module magnitudeTrim
    import csrPkg::*;
#(
    parameter int NADC = 4,
    parameter int MAG_WIDTH = 26,
    parameter int GAIN_WIDTH = 27
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        sumValid,
    input  logic signed [MAG_WIDTH-1:0] sumI [NADC],
    input  logic signed [MAG_WIDTH-1:0] sumQ [NADC],
    input  logic [GAIN_WIDTH-1:0]       gains [NADC],
    output logic                        magValid,
    output logic [MAG_WIDTH-1:0]        mag [NADC]
);

    localparam int PROD_WIDTH = MAG_WIDTH + GAIN_WIDTH;
    localparam int SCALED_WIDTH = PROD_WIDTH - GAIN_FRAC_BITS;

    logic [MAG_WIDTH-1:0]    absI [NADC];
    logic [MAG_WIDTH-1:0]    absQ [NADC];
    logic [MAG_WIDTH-1:0]    bigger [NADC];
    logic [MAG_WIDTH-1:0]    smaller [NADC];
    logic [MAG_WIDTH-1:0]    estimate [NADC];
    logic [MAG_WIDTH-1:0]    estReg [NADC];
    logic                    estValid;
    logic [PROD_WIDTH-1:0]   trimmed [NADC];
    logic [SCALED_WIDTH-1:0] scaled [NADC];
    logic [MAG_WIDTH-1:0]    trimClip [NADC];

    ////////////////////////////////////////
    // stage 1 estimate

    always_comb begin
        for (int ch = 0; ch < NADC; ch++) begin
            // magnitude of a signed MAG_WIDTH value always fits unsigned MAG_WIDTH
            absI[ch] = sumI[ch][MAG_WIDTH-1] ? -sumI[ch] : sumI[ch];
            absQ[ch] = sumQ[ch][MAG_WIDTH-1] ? -sumQ[ch] : sumQ[ch];
            bigger[ch] = (absI[ch] >= absQ[ch]) ? absI[ch] : absQ[ch];
            smaller[ch] = (absI[ch] >= absQ[ch]) ? absQ[ch] : absI[ch];
            // at most 1.5 times half scale, so no clipping needed
            estimate[ch] = bigger[ch] + (smaller[ch] >> 1);
        end
    end

    ////////////////////////////////////////
    // stage 2 gain trim

    always_comb begin
        for (int ch = 0; ch < NADC; ch++) begin
            trimmed[ch] = estReg[ch] * gains[ch];
            scaled[ch] = trimmed[ch][PROD_WIDTH-1:GAIN_FRAC_BITS];
            trimClip[ch] = (|scaled[ch][SCALED_WIDTH-1:MAG_WIDTH]) ?
                           '1 : scaled[ch][MAG_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            estValid <= 1'b0;
            magValid <= 1'b0;
        end else begin
            estValid <= sumValid;
            magValid <= estValid;
        end
    end

    always_ff @(posedge clk) begin
        if (sumValid) begin
            estReg <= estimate;
        end
        if (estValid) begin
            mag <= trimClip;
        end
    end

endmodule

/* logic/controlRegs.sv */
/* Host registers written by one strobe with address. Readback is combinational.
   Gain registers keep only their low GAIN_WIDTH bits. */
`timescale 1ns/1ps

module controlRegs
    import csrPkg::*;
#(
    parameter int NADC = 4,
    parameter int GAIN_WIDTH = 27
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   csrWrite,
    input  csrAddrT                csrAddr,
    input  logic [CSR_WIDTH-1:0]   csrData,
    output logic [CSR_WIDTH-1:0]   csrReadData,
    output logic                   useRms,
    output logic [SHIFT_WIDTH-1:0] sumShift,
    output logic [GAIN_WIDTH-1:0]  gains [NADC],
    input  logic                   overflow,
    output logic                   overflowFlag
);

    logic clearOverflow;

    // gain registers sit at consecutive addresses
    function automatic csrAddrT gainAddr(input int ch);
        return csrAddrT'(int'(ADDR_GAIN0) + ch);
    endfunction

    assign clearOverflow = csrWrite && (csrAddr == ADDR_CONTROL) &&
                           csrData[CTRL_CLEAR_OVERFLOW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            useRms   <= 1'b0;
            sumShift <= '0;
            for (int ch = 0; ch < NADC; ch++) begin
                gains[ch] <= GAIN_WIDTH'(GAIN_UNITY);
            end
        end else if (csrWrite) begin
            case (csrAddr)
                ADDR_CONTROL: useRms <= csrData[CTRL_USE_RMS];
                ADDR_SUM_SHIFT: sumShift <= csrData[SHIFT_WIDTH-1:0];
                default: begin
                    for (int ch = 0; ch < NADC; ch++) begin
                        if (csrAddr == gainAddr(ch)) begin
                            gains[ch] <= csrData[GAIN_WIDTH-1:0];
                        end
                    end
                end
            endcase
        end
    end

    // a new overflow beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            overflowFlag <= 1'b0;
        end else if (overflow) begin
            overflowFlag <= 1'b1;
        end else if (clearOverflow) begin
            overflowFlag <= 1'b0;
        end
    end

    always_comb begin
        csrReadData = '0;
        case (csrAddr)
            ADDR_CONTROL: begin
                csrReadData[CTRL_USE_RMS] = useRms;
                csrReadData[CTRL_OVERFLOW_FLAG] = overflowFlag;
            end
            ADDR_SUM_SHIFT: csrReadData[SHIFT_WIDTH-1:0] = sumShift;
            default: begin
                for (int ch = 0; ch < NADC; ch++) begin
                    if (csrAddr == gainAddr(ch)) begin
                        csrReadData[GAIN_WIDTH-1:0] = gains[ch];
                    end
                end
            end
        endcase
    end

endmodule

/* logic/preliminaryProcessing.sv */
/* Single-clock BPM front end with one trimmed magnitude per channel per turn.
   No back-pressure. Every sample with adcValid is consumed. */
`timescale 1ns/1ps

module preliminaryProcessing
    import demodPkg::*;
    import csrPkg::*;
#(
    parameter int NADC = 4,
    parameter int MAG_WIDTH = 26,
    parameter int GAIN_WIDTH = MAG_WIDTH + 1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 csrWrite,
    input  csrAddrT              csrAddr,
    input  logic [CSR_WIDTH-1:0] csrData,
    output logic [CSR_WIDTH-1:0] csrReadData,
    input  logic                 adcValid,
    input  adcSampleT            adcSample [NADC],
    input  logic                 useThisSample,
    input  logic                 syncStrobe,
    output logic                 magValid,
    output logic [MAG_WIDTH-1:0] mag [NADC],
    output logic                 overflowFlag
);

    ////////////////////////////////////////
    // control path

    logic                   useRms;
    logic [SHIFT_WIDTH-1:0] sumShift;
    logic [GAIN_WIDTH-1:0]  gains [NADC];
    logic                   overflow;

    ////////////////////////////////////////
    // datapath

    logic                        loValid;
    loWordT                      loCos;
    loWordT                      loSin;
    logic                        turnStart;
    logic                        turnEnd;
    logic                        prodValid;
    productT                     prodI [NADC];
    productT                     prodQ [NADC];
    logic                        prodTurnStart;
    logic                        prodTurnEnd;
    logic                        sumValid;
    logic signed [MAG_WIDTH-1:0] sumI [NADC];
    logic signed [MAG_WIDTH-1:0] sumQ [NADC];

    controlRegs #(
        .NADC(NADC),
        .GAIN_WIDTH(GAIN_WIDTH)
    ) controlRegsI (
        .clk(clk),
        .rstN(rstN),
        .csrWrite(csrWrite),
        .csrAddr(csrAddr),
        .csrData(csrData),
        .csrReadData(csrReadData),
        .useRms(useRms),
        .sumShift(sumShift),
        .gains(gains),
        .overflow(overflow),
        .overflowFlag(overflowFlag)
    );

    localOscillator localOscillatorI (
        .clk(clk),
        .rstN(rstN),
        .adcValid(adcValid),
        .syncStrobe(syncStrobe),
        .loValid(loValid),
        .loCos(loCos),
        .loSin(loSin),
        .turnStart(turnStart),
        .turnEnd(turnEnd)
    );

    demodMixer #(
        .NADC(NADC)
    ) demodMixerI (
        .clk(clk),
        .rstN(rstN),
        .loValid(loValid),
        .loCos(loCos),
        .loSin(loSin),
        .turnStart(turnStart),
        .turnEnd(turnEnd),
        .adcSample(adcSample),
        .useThisSample(useThisSample),
        .useRms(useRms),
        .prodValid(prodValid),
        .prodI(prodI),
        .prodQ(prodQ),
        .prodTurnStart(prodTurnStart),
        .prodTurnEnd(prodTurnEnd)
    );

    turnAccumulator #(
        .NADC(NADC),
        .MAG_WIDTH(MAG_WIDTH)
    ) turnAccumulatorI (
        .clk(clk),
        .rstN(rstN),
        .prodValid(prodValid),
        .prodI(prodI),
        .prodQ(prodQ),
        .prodTurnStart(prodTurnStart),
        .prodTurnEnd(prodTurnEnd),
        .sumShift(sumShift),
        .sumValid(sumValid),
        .sumI(sumI),
        .sumQ(sumQ),
        .overflow(overflow)
    );

    magnitudeTrim #(
        .NADC(NADC),
        .MAG_WIDTH(MAG_WIDTH),
        .GAIN_WIDTH(GAIN_WIDTH)
    ) magnitudeTrimI (
        .clk(clk),
        .rstN(rstN),
        .sumValid(sumValid),
        .sumI(sumI),
        .sumQ(sumQ),
        .gains(gains),
        .magValid(magValid),
        .mag(mag)
    );

endmodule

/* test/preliminaryProcessingTb.sv */
/* Reads test/demodInput.txt, so the simulator must run from the project root.
   Sample and magnitude lines in that file carry exactly four channels. */
`timescale 1ns/1ps

module preliminaryProcessingTb
    import demodPkg::*;
    import csrPkg::*;
();

    localparam int NADC = 4;
    localparam int MAG_WIDTH = 26;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    localparam int MAG_WAIT_LIMIT = 16;
    localparam int CYCLES_PER_LINE = 4;
    localparam int CYCLE_MARGIN = 100;
    localparam string INPUT_FILE = "test/demodInput.txt";

    logic                 clk;
    logic                 rstN;
    logic                 csrWrite;
    csrAddrT              csrAddr;
    logic [CSR_WIDTH-1:0] csrData;
    logic [CSR_WIDTH-1:0] csrReadData;
    logic                 adcValid;
    adcSampleT            adcSample [NADC];
    logic                 useThisSample;
    logic                 syncStrobe;
    logic                 magValid;
    logic [MAG_WIDTH-1:0] mag [NADC];
    logic                 overflowFlag;

    int cycleCount = 0;
    int cycleLimit = 0;
    int sampleIn [NADC];
    int magExpected [NADC];

    preliminaryProcessing #(
        .NADC(NADC),
        .MAG_WIDTH(MAG_WIDTH)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .csrWrite(csrWrite),
        .csrAddr(csrAddr),
        .csrData(csrData),
        .csrReadData(csrReadData),
        .adcValid(adcValid),
        .adcSample(adcSample),
        .useThisSample(useThisSample),
        .syncStrobe(syncStrobe),
        .magValid(magValid),
        .mag(mag),
        .overflowFlag(overflowFlag)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // reporting

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Fail at %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    // watchdog limit is set once the file length is known
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            abortRun($sformatf("timeout after %0d cycles", cycleCount));
        end
    end

    ////////////////////////////////////////
    // stimulus driven on the falling edge

    task automatic driveIdle();
        csrWrite = 1'b0;
        adcValid = 1'b0;
        syncStrobe = 1'b0;
        useThisSample = 1'b0;
        for (int ch = 0; ch < NADC; ch++) begin
            adcSample[ch] = '0;
        end
    endtask

    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        driveIdle();
        csrWrite = 1'b1;
        csrAddr = csrAddrT'(addr[2:0]);
        csrData = data;
    endtask

    // readback is combinational and sampled mid low phase
    task automatic readReg(input logic [31:0] addr, input logic [31:0] expected);
        @(negedge clk);
        driveIdle();
        csrAddr = csrAddrT'(addr[2:0]);
        #(CLK_PERIOD / 4);
        checkValue($sformatf("csrReadData(addr %0d)", addr), 64'(csrReadData), 64'(expected));
    endtask

    task automatic driveSample(input int valid, input int sync, input int gate);
        @(negedge clk);
        driveIdle();
        adcValid = (valid != 0);
        syncStrobe = (sync != 0);
        useThisSample = (gate != 0);
        for (int ch = 0; ch < NADC; ch++) begin
            adcSample[ch] = adcSampleT'(sampleIn[ch]);
        end
    endtask

    task automatic checkTurn(input int flagExpected);
        int waited;
        @(negedge clk);
        driveIdle();
        waited = 0;
        while (!magValid && waited < MAG_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!magValid) begin
            abortRun($sformatf("magValid did not rise within %0d cycles", MAG_WAIT_LIMIT));
        end else begin
            for (int ch = 0; ch < NADC; ch++) begin
                checkValue($sformatf("mag[%0d]", ch), 64'(mag[ch]), 64'(magExpected[ch]));
            end
            checkValue("overflowFlag", 64'(overflowFlag), 64'(flagExpected));
        end
    endtask

    ////////////////////////////////////////
    // command loop

    initial begin
        int               fd;
        int               code;
        int               lineCount;
        logic [7:0]       cmd;
        logic [31:0]      addr;
        logic [31:0]      data;
        int               valid;
        int               sync;
        int               gate;
        int               flag;
        logic [8*256-1:0] lineBuf;
        bit               done;

        rstN = 1'b0;
        csrAddr = ADDR_CONTROL;
        csrData = '0;
        driveIdle();

        // timeout grows with the file length
        lineCount = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            abortRun("cannot open the stimulus file test/demodInput.txt");
        end
        while ($fgets(lineBuf, fd) != 0) begin
            lineCount++;
        end
        $fclose(fd);
        cycleLimit = CYCLES_PER_LINE * lineCount + CYCLE_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("magValid", 64'(magValid), 64'(0));
        checkValue("overflowFlag", 64'(overflowFlag), 64'(0));

        fd = $fopen(INPUT_FILE, "r");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(lineBuf, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        if (code != 2) begin
                            abortRun("malformed register write line in the input file");
                        end else begin
                            writeReg(addr, data);
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        if (code != 2) begin
                            abortRun("malformed register read line in the input file");
                        end else begin
                            readReg(addr, data);
                        end
                    end
                    "S": begin
                        code = $fscanf(fd, "%d %d %d %d %d %d %d", valid, sync, gate,
                                       sampleIn[0], sampleIn[1], sampleIn[2], sampleIn[3]);
                        if (code != 7) begin
                            abortRun("malformed sample line in the input file");
                        end else begin
                            driveSample(valid, sync, gate);
                        end
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %d %d %d %d", magExpected[0], magExpected[1],
                                       magExpected[2], magExpected[3], flag);
                        if (code != 5) begin
                            abortRun("malformed expected magnitude line in the input file");
                        end else begin
                            checkTurn(flag);
                        end
                    end
                    default: abortRun($sformatf("unknown command '%c' in the input file", cmd));
                endcase
            end
        end
        $fclose(fd);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* test/demodInput.txt */
# W addr data | R addr expected (hex) | S valid sync gate s0 s1 s2 s3 (decimal)
# E mag0 mag1 mag2 mag3 overflowFlag (decimal)
R 0 00000000
R 1 00000000
R 4 01000000
R 5 01000000
R 6 01000000
R 7 01000000
# cosine turn, unity gain, shift 0
S 1 0 1 10 20 -30 48
S 1 0 1 7 14 -21 34
S 1 0 1 0 0 0 0
S 1 0 1 -7 -14 21 -34
S 1 0 1 -10 -20 30 -48
S 1 0 1 -7 -14 21 -34
S 1 0 1 0 0 0 0
S 1 0 1 7 14 -21 34
E 5216488 10432976 15649464 25187432 0
# gain trim 0.5 1.5 1.25 4.0, upper bits of gain3 dropped
W 4 00800000
W 5 01800000
W 6 01400000
W 7 84000000
R 7 04000000
S 1 0 1 10 -15 40 50
S 1 0 1 0 5 30 40
S 1 0 1 20 3 -40 0
S 1 0 1 0 -2 10 -40
S 1 0 1 -10 15 -40 -50
S 1 0 1 0 -5 -30 -40
S 1 0 1 -20 -3 40 0
S 1 0 1 0 2 -10 40
E 3276775 4958778 19660650 67108863 0
W 4 01000000
W 5 01000000
W 6 01000000
W 7 01000000
# full scale at shift 0 saturates
S 1 0 1 32767 -32768 0 10
S 1 0 1 23170 -23170 0 7
S 1 0 1 0 0 0 0
S 1 0 1 -23170 23170 0 -7
S 1 0 1 -32767 32767 0 -10
S 1 0 1 -23170 23170 0 -7
S 1 0 1 0 0 0 0
S 1 0 1 23170 -23170 0 7
E 33554431 33554432 0 5216488 1
R 0 80000000
W 1 00000009
R 1 00000009
S 1 0 1 32767 -32768 0 10
S 1 0 1 23170 -23170 0 7
S 1 0 1 0 0 0 0
S 1 0 1 -23170 23170 0 -7
S 1 0 1 -32767 32767 0 -10
S 1 0 1 -23170 23170 0 -7
S 1 0 1 0 0 0 0
S 1 0 1 23170 -23170 0 7
E 33553285 33553542 0 10188 1
W 0 00000002
R 0 00000000
# RMS mode, shift 4, steps 2 and 6 gated off
W 1 00000004
W 0 00000001
R 0 00000001
S 1 0 1 100 -200 1000 3
S 1 0 1 100 300 -1000 5
S 1 0 0 100 5000 32767 7
S 1 0 1 100 -100 1000 11
S 1 0 1 100 50 -1000 13
S 1 0 1 100 7 1000 17
S 1 0 0 100 9999 -32768 19
S 1 0 1 100 1 -1000 23
E 7500 17818 750000 142 0
W 0 00000000
W 1 00000000
# partial turn, then sync restart with gaps
S 1 0 1 30000 30000 30000 30000
S 1 0 1 -30000 -30000 -30000 -30000
S 0 0 1 0 0 0 0
S 1 0 1 30000 30000 30000 30000
S 1 1 1 1 3 -100 0
S 1 0 1 2 0 50 -1
S 0 0 0 0 0 0 0
S 1 0 1 3 1 25 0
S 1 0 1 4 0 -10 0
S 1 0 1 5 0 20 0
S 1 0 1 6 0 0 0
S 1 0 1 7 0 -5 0
S 1 0 1 8 0 1 0
E 1527874 458748 13848323 139021 0

/* files.f */
logic/demodPkg.sv
logic/csrPkg.sv
logic/localOscillator.sv
logic/demodMixer.sv
logic/turnAccumulator.sv
logic/magnitudeTrim.sv
logic/controlRegs.sv
logic/preliminaryProcessing.sv
test/preliminaryProcessingTb.sv

/* Makefile */
# Verilator build and run of the preliminaryProcessing testbench
VERILATOR ?= verilator
TOP       ?= preliminaryProcessingTb
LOG       ?= sim.log
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
